/* design/i2c_target_pkg.sv */
package i2c_target_pkg;

    localparam logic [6:0] device_addr   = 7'h48;   // Target address on the bus
    localparam logic [7:0] register_addr = 8'h22;   // Only register pointer we answer
    localparam int         byte_bits     = 8;
    localparam int         data_width    = 16;

    typedef logic [3:0] bit_count_t;

    // One synchronized bus line
    typedef struct packed {
        logic level;
        logic rise;
        logic fall;
    } line_state_t;

    typedef struct packed {
        line_state_t sda;
        line_state_t scl;
        logic        start;   // One-clock strobes
        logic        stop;
    } bus_event_t;

    // FSM requests toward the pad driver
    typedef struct packed {
        logic ack_req;
        logic will_ack;
        logic tx_en;
        logic tx_bit;
    } sda_ctrl_t;

    typedef enum logic [3:0] {
        bus_free,
        address_shift,
        address_ack,
        subaddr_shift,
        subaddr_ack,
        write_shift,
        write_ack,
        read_prep,
        read_shift,
        read_ackin
    } target_state_e;

    typedef enum logic [1:0] {
        evaluate,
        wait_scl_low,
        wait_scl_rise
    } ack_phase_e;

endpackage

/* design/line_sampler.sv */
`timescale 1ns/1ps

module line_sampler
    import i2c_target_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        line,
    output line_state_t state
);

    logic [1:0] sync;     // sync[1] is the metastability-safe copy
    logic       prev;     // Last synchronized value for edge detection
    logic       rise_q;
    logic       fall_q;

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            sync   <= 2'b11;    // Idle bus is high
            prev   <= 1'b1;
            rise_q <= 1'b0;
            fall_q <= 1'b0;
        end
        else
        begin
            sync   <= {sync[0], line};
            prev   <= sync[1];
            rise_q <= sync[1] & ~prev;
            fall_q <= ~sync[1] & prev;
        end
    end

    assign state = '{level: sync[1], rise: rise_q, fall: fall_q};

endmodule

/* design/bus_condition.sv */
`timescale 1ns/1ps

module bus_condition
    import i2c_target_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  line_state_t sda_line,
    input  line_state_t scl_line,
    output bus_event_t  bus
);

    // SDA only moves while SCL is low during data bits, so an SDA edge
    // with SCL high can only be a START or a STOP
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            bus.sda   <= '{level: 1'b1, rise: 1'b0, fall: 1'b0};
            bus.scl   <= '{level: 1'b1, rise: 1'b0, fall: 1'b0};
            bus.start <= 1'b0;
            bus.stop  <= 1'b0;
        end
        else
        begin
            bus.sda   <= sda_line;     // Delayed to line up with the strobes
            bus.scl   <= scl_line;
            bus.start <= sda_line.fall & scl_line.level;
            bus.stop  <= sda_line.rise & scl_line.level;
        end
    end

endmodule

/* design/sda_driver.sv */
`timescale 1ns/1ps

module sda_driver
    import i2c_target_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  bus_event_t bus,
    input  sda_ctrl_t  ctrl,
    inout  wire        sda
);

    logic ack_hold;       // Set across the ninth clock
    logic sda_oe;         // 1 pulls the pad low
    logic sda_oe_next;

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            ack_hold <= 1'b0;
        else if (bus.stop)
            ack_hold <= 1'b0;
        else if (ctrl.ack_req)
            ack_hold <= 1'b1;
        else if (bus.scl.fall)
            ack_hold <= 1'b0;   // ACK clock finished
    end

    always_comb
    begin
        sda_oe_next = 1'b0;
        if (ack_hold && ctrl.will_ack)
            sda_oe_next = 1'b1;
        else if (ctrl.tx_en)
            sda_oe_next = bus.scl.level ? sda_oe : ~ctrl.tx_bit;  // Frozen while SCL high
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            sda_oe <= 1'b0;
        else
            sda_oe <= sda_oe_next;
    end

    assign sda = sda_oe ? 1'b0 : 1'bz;

endmodule

/* design/target_fsm.sv */
`timescale 1ns/1ps

module target_fsm
    import i2c_target_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  bus_event_t bus,
    output sda_ctrl_t  ctrl,
    output logic       busy
);

    target_state_e         state;
    ack_phase_e            ack_phase;
    bit_count_t            bit_cnt;
    logic [1:0]            byte_cnt;      // Bytes already read in this transaction
    logic [6:0]            addr_reg;
    logic                  rw_mode;       // 1 for a read
    logic [7:0]            subaddr_reg;
    logic [7:0]            wr_byte;       // Incoming data byte
    logic [data_width-1:0] data_reg;
    logic [7:0]            rd_byte;       // Outgoing byte, shifted MSB first
    logic                  ack_req;
    logic                  will_ack;
    logic                  tx_en;
    logic                  tx_bit;
    logic                  ack_match;
    target_state_e         ack_next;
    logic                  last_rx_bit;

    assign last_rx_bit = bus.scl.rise && (bit_cnt == bit_count_t'(byte_bits - 1));

    // Match result and follow-on state for the byte being acknowledged
    always_comb
    begin
        case (state)
            address_ack:
            begin
                ack_match = (addr_reg == device_addr);
                ack_next  = ack_match ? subaddr_shift : bus_free;
            end
            subaddr_ack:
            begin
                ack_match = (subaddr_reg == register_addr);
                if (!ack_match)
                    ack_next = bus_free;
                else if (rw_mode)
                    ack_next = read_prep;
                else
                    ack_next = write_shift;
            end
            default:
            begin
                ack_match = 1'b1;     // Data bytes are always taken
                ack_next  = write_shift;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state       <= bus_free;
            ack_phase   <= evaluate;
            bit_cnt     <= '0;
            byte_cnt    <= '0;
            addr_reg    <= '0;
            rw_mode     <= 1'b0;
            subaddr_reg <= '0;
            wr_byte     <= '0;
            data_reg    <= '0;
            rd_byte     <= '0;
            ack_req     <= 1'b0;
            will_ack    <= 1'b0;
            tx_en       <= 1'b0;
            tx_bit      <= 1'b0;
            busy        <= 1'b0;
        end
        else if (bus.stop)
        begin
            state     <= bus_free;
            ack_phase <= evaluate;
            ack_req   <= 1'b0;
            will_ack  <= 1'b0;
            tx_en     <= 1'b0;
            busy      <= 1'b0;
        end
        else if (bus.start)         // Also covers a repeated START
        begin
            state     <= address_shift;
            ack_phase <= evaluate;
            bit_cnt   <= '0;
            byte_cnt  <= '0;
            ack_req   <= 1'b0;
            will_ack  <= 1'b0;
            tx_en     <= 1'b0;
            busy      <= 1'b1;
        end
        else
        begin
            case (state)
                bus_free:
                    bit_cnt <= '0;
                address_shift:
                    if (bus.scl.rise)
                    begin
                        {addr_reg, rw_mode} <= {addr_reg[5:0], rw_mode, bus.sda.level};
                        bit_cnt <= bit_cnt + 4'd1;
                        if (last_rx_bit)
                            state <= address_ack;
                    end
                subaddr_shift:
                    if (bus.scl.rise)
                    begin
                        subaddr_reg <= {subaddr_reg[6:0], bus.sda.level};
                        bit_cnt     <= bit_cnt + 4'd1;
                        if (last_rx_bit)
                            state <= subaddr_ack;
                    end
                write_shift:
                    if (bus.scl.rise)
                    begin
                        wr_byte <= {wr_byte[6:0], bus.sda.level};
                        bit_cnt <= bit_cnt + 4'd1;
                        if (last_rx_bit)
                        begin
                            // Whole byte in, push it into the low end
                            data_reg <= {data_reg[data_width-byte_bits-1:0],
                                         wr_byte[6:0], bus.sda.level};
                            state    <= write_ack;
                        end
                    end
                address_ack, subaddr_ack, write_ack:
                    case (ack_phase)
                        evaluate:
                        begin
                            will_ack  <= ack_match;
                            ack_phase <= wait_scl_low;
                        end
                        wait_scl_low:
                            if (!bus.scl.level)
                            begin
                                ack_req   <= 1'b1;     // Driver starts the ACK hold
                                ack_phase <= wait_scl_rise;
                            end
                        wait_scl_rise:
                            if (bus.scl.rise)
                            begin
                                ack_req   <= 1'b0;
                                ack_phase <= evaluate;
                                bit_cnt   <= '0;
                                state     <= ack_next;
                            end
                        default:
                            ack_phase <= evaluate;
                    endcase
                read_prep:
                begin
                    rd_byte <= (byte_cnt == 2'd0) ? data_reg[data_width-1 -: byte_bits]
                                                  : data_reg[byte_bits-1:0];
                    tx_en   <= 1'b1;
                    bit_cnt <= '0;
                    state   <= read_shift;
                end
                read_shift:
                    if (bus.scl.fall)
                    begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == bit_count_t'(byte_bits))
                        begin
                            tx_en <= 1'b0;     // Hand SDA to the master for its ACK
                            state <= read_ackin;
                        end
                        else
                        begin
                            tx_bit  <= rd_byte[7];
                            rd_byte <= {rd_byte[6:0], 1'b0};
                        end
                    end
                read_ackin:
                    if (bus.scl.rise)
                    begin
                        if (!bus.sda.level)
                        begin
                            if (byte_cnt != 2'd3)
                                byte_cnt <= byte_cnt + 2'd1;
                            state <= read_prep;
                        end
                        else
                            state <= bus_free;  // NACK ends the read
                    end
                default:
                    state <= bus_free;
            endcase
        end
    end

    assign ctrl = '{ack_req: ack_req, will_ack: will_ack, tx_en: tx_en, tx_bit: tx_bit};

endmodule

/* design/i2c_target.sv */
`timescale 1ns/1ps

module i2c_target
    import i2c_target_pkg::*;
(
    input  logic clk,
    input  logic reset_n,
    input  logic scl,
    inout  wire  sda,
    output logic busy
);

    wire              [1:0] pins;      // Index 0 is SDA, 1 is SCL
    line_state_t      [1:0] lines;
    bus_event_t             bus;
    sda_ctrl_t              ctrl;

    assign pins = {scl, sda};

    genvar i;
    generate
        for (i = 0; i < 2; i++)
        begin : g_sampler
            line_sampler u_sampler (
                .clk     (clk),
                .reset_n (reset_n),
                .line    (pins[i]),
                .state   (lines[i])
            );
        end
    endgenerate

    bus_condition u_bus_condition (
        .clk      (clk),
        .reset_n  (reset_n),
        .sda_line (lines[0]),
        .scl_line (lines[1]),
        .bus      (bus)
    );

    target_fsm u_target_fsm (
        .clk     (clk),
        .reset_n (reset_n),
        .bus     (bus),
        .ctrl    (ctrl),
        .busy    (busy)
    );

    sda_driver u_sda_driver (
        .clk     (clk),
        .reset_n (reset_n),
        .bus     (bus),
        .ctrl    (ctrl),
        .sda     (sda)
    );

endmodule

/* sim/i2c_master_bfm.svh */
`ifndef I2C_MASTER_BFM_SVH
`define I2C_MASTER_BFM_SVH

// Bit-level I2C master, every SCL phase is 12 clocks
// sda_low and scl_low pull the open-drain lines, 0 releases them

task automatic wait_clocks(input int n);
    repeat (n)
        @(posedge clk);
    #(drive_delay);                  // Drive and sample just after the edge
endtask

// Works from an idle bus and as a repeated START with SCL low
task automatic bus_start();
    wait_clocks(4);
    sda_low = 1'b0;
    wait_clocks(8);
    scl_low = 1'b0;
    wait_clocks(12);
    sda_low = 1'b1;                  // SDA falls while SCL is high
    wait_clocks(12);
    scl_low = 1'b1;
endtask

task automatic bus_stop();
    wait_clocks(4);
    sda_low = 1'b1;
    wait_clocks(8);
    scl_low = 1'b0;
    wait_clocks(12);
    sda_low = 1'b0;                  // SDA rises while SCL is high
    wait_clocks(12);
endtask

// ack comes back as the SDA level at the ninth clock, 0 is an ACK
task automatic write_byte(input logic [7:0] data, output logic ack);
    logic [7:0] shift;
    shift = data;
    repeat (8)
    begin
        wait_clocks(4);
        sda_low = ~shift[7];         // MSB first
        shift   = {shift[6:0], 1'b0};
        wait_clocks(8);
        scl_low = 1'b0;
        wait_clocks(12);
        scl_low = 1'b1;
    end
    wait_clocks(4);
    sda_low = 1'b0;                  // Target owns SDA for the ACK
    wait_clocks(8);
    scl_low = 1'b0;
    wait_clocks(6);
    ack = sda;
    wait_clocks(6);
    scl_low = 1'b1;
endtask

task automatic read_byte(input logic send_ack, output logic [7:0] data);
    data = 8'h00;
    repeat (8)
    begin
        wait_clocks(4);
        sda_low = 1'b0;
        wait_clocks(8);
        scl_low = 1'b0;
        wait_clocks(6);
        data = {data[6:0], sda};
        wait_clocks(6);
        scl_low = 1'b1;
    end
    wait_clocks(4);
    sda_low = send_ack;              // Low asks for another byte
    wait_clocks(8);
    scl_low = 1'b0;
    wait_clocks(12);
    scl_low = 1'b1;
endtask

`endif

/* sim/tb_i2c_target.sv */
`timescale 1ns/1ps

module tb_i2c_target;

    localparam int          drive_delay = 5;      // ns after the rising edge
    localparam int          total_bytes = 55;     // Bytes moved by the whole sequence
    localparam int          watchdog_ns = total_bytes * 9 * 24 * 40 + 200_000;
    localparam logic [31:0] seed        = 32'h07e978a2;

    logic        clk;
    logic        reset_n;
    logic        sda_low;
    logic        scl_low;
    logic        busy;
    wire         sda;
    wire         scl;
    logic [31:0] lcg_state;
    logic [7:0]  written_q[$];        // Data bytes the target accepted since reset
    string       name_q[$];
    logic [7:0]  got_q[$];
    logic [7:0]  exp_q[$];

    assign sda = sda_low ? 1'b0 : 1'bz;
    assign scl = scl_low ? 1'b0 : 1'bz;
    pullup (sda);
    pullup (scl);

    i2c_target dut (
        .clk     (clk),
        .reset_n (reset_n),
        .scl     (scl),
        .sda     (sda),
        .busy    (busy)
    );

    always #20 clk = ~clk;

    `include "i2c_master_bfm.svh"

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Register model where every written byte enters at the low end
    function automatic logic [7:0] expected_read(input int n);
        logic [15:0] model;
        model = 16'h0000;
        foreach (written_q[i])
            model = {model[7:0], written_q[i]};
        return (n == 0) ? model[15:8] : model[7:0];
    endfunction

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic record(input string name, input logic [7:0] got, input logic [7:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    task automatic send_and_expect(input string name, input logic [7:0] data, input logic exp_sda);
        logic ack;
        write_byte(data, ack);
        record(name, 8'(ack), 8'(exp_sda));
    endtask

    task automatic send_random_data();
        logic [7:0] data;
        lcg_state = lcg_next(lcg_state);
        data      = lcg_state[23:16];
        written_q.push_back(data);
        send_and_expect("data ack", data, 1'b0);
    endtask

    task automatic write_round(input int n);
        bus_start();
        send_and_expect("address ack", 8'h90, 1'b0);
        send_and_expect("register ack", 8'h22, 1'b0);
        repeat (n)
            send_random_data();
        bus_stop();
    endtask

    task automatic read_round(input int count);
        logic [7:0] data;
        bus_start();
        send_and_expect("address ack", 8'h91, 1'b0);
        send_and_expect("register ack", 8'h22, 1'b0);
        for (int n = 0; n < count; n++)
        begin
            read_byte(n < count - 1, data);    // NACK on the last byte
            record("read data", data, expected_read(n));
        end
        bus_stop();
        record("busy", 8'(busy), 8'h00);
    endtask

    // Compares the recorded samples away from the driving edge
    initial
    begin : compare_proc
        string      name;
        logic [7:0] got;
        logic [7:0] exp;
        forever
        begin
            @(negedge clk);
            while (got_q.size() != 0)
            begin
                name = name_q.pop_front();
                got  = got_q.pop_front();
                exp  = exp_q.pop_front();
                check_value(name, got, exp);
            end
        end
    end

    initial
    begin : watchdog
        #(watchdog_ns);
        $display("Timeout: the sequence did not finish within %0d ns", watchdog_ns);
        $display("Test failed");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin : stimulus
        clk       = 1'b0;
        reset_n   = 1'b0;
        sda_low   = 1'b0;
        scl_low   = 1'b0;
        lcg_state = seed;
        repeat (10)
            @(posedge clk);
        #(drive_delay);
        reset_n = 1'b1;
        wait_clocks(4);
        record("busy", 8'(busy), 8'h00);
        record("sda", 8'(sda), 8'h01);

        bus_start();
        record("busy", 8'(busy), 8'h01);
        bus_stop();
        record("busy", 8'(busy), 8'h00);

        // The target must stay off SDA up to the STOP after a foreign address
        bus_start();
        send_and_expect("address ack", 8'h90, 1'b0);
        bus_stop();
        bus_start();
        send_and_expect("address nack", 8'h92, 1'b1);
        send_and_expect("released sda", 8'h22, 1'b1);
        send_and_expect("released sda", 8'h00, 1'b1);
        bus_stop();

        bus_start();
        send_and_expect("address ack", 8'h90, 1'b0);
        send_and_expect("register nack", 8'h23, 1'b1);
        bus_stop();

        for (int n = 1; n <= 4; n++)
        begin
            write_round(n);
            read_round(3);
        end

        // Repeated START between data bytes
        bus_start();
        send_and_expect("address ack", 8'h90, 1'b0);
        send_and_expect("register ack", 8'h22, 1'b0);
        send_random_data();
        bus_start();
        send_and_expect("restart address nack", 8'h92, 1'b1);
        bus_start();
        send_and_expect("restart address ack", 8'h90, 1'b0);
        send_and_expect("register ack", 8'h22, 1'b0);
        send_random_data();
        bus_stop();
        read_round(2);

        while (got_q.size() != 0)
            @(posedge clk);
        wait_clocks(2);
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* i2c_target.f */
+incdir+sim
design/i2c_target_pkg.sv
design/line_sampler.sv
design/bus_condition.sv
design/sda_driver.sv
design/target_fsm.sv
design/i2c_target.sv
sim/tb_i2c_target.sv

/* Makefile */
# Verilator build for the I2C target testbench
# Any variable can be overridden, e.g. make sim LOG=run1.log

VERILATOR ?= verilator
FILELIST  ?= i2c_target.f
TOP       ?= tb_i2c_target
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(TOP): $(FILELIST) design/*.sv sim/*.sv sim/*.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BUILD_DIR)/$(TOP)
	$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
